//--- merge_sort.f
+incdir+.
merge_sort_pkg.sv
tuple_fifo.sv
merge_control.sv
bitonic_merger.sv
tuple_merger.sv
tb_tuple_merger.sv

//--- Bender.yml
package:
  name: merge_sort

export_include_dirs:
  - .

sources:
  - merge_sort_pkg.sv
  - tuple_fifo.sv
  - merge_control.sv
  - bitonic_merger.sv
  - tuple_merger.sv
  - target: test
    files:
      - tb_tuple_merger.sv

//--- tb_tuple_merger.sv
`timescale 1ns/10ps
`default_nettype none

`include "merge_sort_consts.svh"

module tb_tuple_merger;

   typedef struct packed {
      logic [7:0]           a_len;       // data tuples in stream A.
      logic [7:0]           b_len;
      merge_sort_pkg::key_t b_start;     // B's keys begin above this value.
      merge_sort_pkg::key_t gap_max;
      logic                 rand_ready;
   } test_row_t;

   localparam int NUM_ROWS = 9;

   test_row_t rows [NUM_ROWS] = '{
      '{8'd6,  8'd6,  32'd0,          32'd200,  1'b0},   // interleaved, equal length.
      '{8'd4,  8'd5,  32'h1000_0000,  32'd16,   1'b0},   // all of A below all of B.
      '{8'd7,  8'd2,  32'd0,          32'd100,  1'b0},
      '{8'd0,  8'd5,  32'd0,          32'd50,   1'b0},   // A is only a terminator.
      '{8'd3,  8'd0,  32'd0,          32'd50,   1'b0},
      '{8'd5,  8'd5,  32'd0,          32'd1,    1'b0},   // identical keys on both sides.
      '{8'd40, 8'd37, 32'd0,          32'd1000, 1'b1},
      '{8'd0,  8'd0,  32'd0,          32'd1,    1'b0},
      '{8'd25, 8'd30, 32'd5,          32'd3,    1'b1}
   };

   logic                   i_clk;
   logic                   i_reset;
   merge_sort_pkg::tuple_t i_a_tuple;
   logic                   i_a_empty;
   logic                   o_a_read;
   merge_sort_pkg::tuple_t i_b_tuple;
   logic                   i_b_empty;
   logic                   o_b_read;
   logic                   i_out_ready;
   logic                   o_out_valid;
   merge_sort_pkg::tuple_t o_out_tuple;

   logic [31:0]            lcg_state = 32'd85;
   int unsigned            cycle_count = 0;
   int unsigned            timeout_limit = 500;
   merge_sort_pkg::key_t   key_buf[$];
   merge_sort_pkg::key_t   keys_a[$];
   merge_sort_pkg::key_t   keys_b[$];
   merge_sort_pkg::tuple_t tuple_buf[$];
   merge_sort_pkg::tuple_t stream_a[$];
   merge_sort_pkg::tuple_t stream_b[$];
   merge_sort_pkg::tuple_t expected[$];

   tuple_merger u_tuple_merger (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_a_tuple   (i_a_tuple),
      .i_a_empty   (i_a_empty),
      .o_a_read    (o_a_read),
      .i_b_tuple   (i_b_tuple),
      .i_b_empty   (i_b_empty),
      .o_b_read    (o_b_read),
      .i_out_ready (i_out_ready),
      .o_out_valid (o_out_valid),
      .o_out_tuple (o_out_tuple)
   );

   initial begin
      i_clk = 1'b0;
      forever #2 i_clk = ~i_clk;
   end

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_tuple(input string name, input merge_sort_pkg::tuple_t got,
                              input merge_sort_pkg::tuple_t exp);
      if (got !== exp)
         stop_with_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
   endtask

   task automatic check_count(input string name, input int unsigned got,
                              input int unsigned exp);
      if (got !== exp)
         stop_with_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
   endtask

   task automatic check_strobe(input string name, input logic got, input logic exp);
      if (got !== exp)
         stop_with_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
   endtask

   // ascending keys with positive gaps, so no data key is ever zero.
   task automatic make_keys(input int unsigned n_tuples, input merge_sort_pkg::key_t start,
                            input merge_sort_pkg::key_t gap_max);
      merge_sort_pkg::key_t running;
      running = start;
      key_buf.delete();
      for (int i = 0; i < n_tuples * `MS_KEYS; i++) begin
         running = running + 1 + ((next_random() >> 8) % gap_max);
         key_buf.push_back(running);
      end
   endtask

   task automatic pack_keys();
      merge_sort_pkg::tuple_t tup;
      tuple_buf.delete();
      for (int t = 0; t < key_buf.size() / `MS_KEYS; t++) begin
         for (int k = 0; k < `MS_KEYS; k++) tup[k] = key_buf[t*`MS_KEYS + k];
         tuple_buf.push_back(tup);
      end
      tuple_buf.push_back('0);   // terminator closes every stream.
   endtask

   task automatic run_row(input int r);
      test_row_t   row;
      int unsigned a_idx;
      int unsigned b_idx;
      int unsigned got;
      int unsigned i;
      int unsigned j;
      logic        a_rd;
      logic        b_rd;
      row = rows[r];
      make_keys(row.a_len, 32'd0, row.gap_max);
      keys_a = key_buf;
      pack_keys();
      stream_a = tuple_buf;
      make_keys(row.b_len, row.b_start, row.gap_max);
      keys_b = key_buf;
      pack_keys();
      stream_b = tuple_buf;
      key_buf.delete();
      i = 0;
      j = 0;
      while (i < keys_a.size() || j < keys_b.size()) begin
         if (j >= keys_b.size() || (i < keys_a.size() && keys_a[i] <= keys_b[j])) begin
            key_buf.push_back(keys_a[i]);
            i++;
         end else begin
            key_buf.push_back(keys_b[j]);
            j++;
         end
      end
      pack_keys();
      expected = tuple_buf;
      a_idx = 0;
      b_idx = 0;
      got   = 0;
      @(posedge i_clk);
      i_a_tuple <= stream_a[0];
      i_a_empty <= 1'b0;
      i_b_tuple <= stream_b[0];
      i_b_empty <= 1'b0;
      while (got < expected.size()) begin
         @(negedge i_clk);
         if (u_tuple_merger.a_full) check_strobe("o_a_read", o_a_read, 1'b0);
         if (u_tuple_merger.b_full) check_strobe("o_b_read", o_b_read, 1'b0);
         if (o_out_valid) begin   // popped by the DUT at the next edge.
            check_tuple($sformatf("o_out_tuple (row %0d, tuple %0d)", r, got),
                        o_out_tuple, expected[got]);
            got++;
         end
         a_rd = o_a_read;
         b_rd = o_b_read;
         @(posedge i_clk);
         if (a_rd) a_idx++;
         if (b_rd) b_idx++;
         i_a_empty   <= (a_idx >= stream_a.size());
         i_a_tuple   <= (a_idx < stream_a.size()) ? stream_a[a_idx] : '0;
         i_b_empty   <= (b_idx >= stream_b.size());
         i_b_tuple   <= (b_idx < stream_b.size()) ? stream_b[b_idx] : '0;
         i_out_ready <= row.rand_ready ? (next_random() >> 16) % 8 < 3 : 1'b1;
      end
      check_count("tuples read from A", a_idx, stream_a.size());
      check_count("tuples read from B", b_idx, stream_b.size());
      i_out_ready <= 1'b1;
      // any extra tuple would show up here.
      repeat (10) begin
         @(negedge i_clk);
         if (o_out_valid) begin
            got++;
         end
      end
      check_count("output tuples", got, row.a_len + row.b_len + 1);
   endtask

   always @(posedge i_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_limit)
         stop_with_error("timeout: the merger stopped producing output");
   end

   initial begin
      i_reset     = 1'b1;
      i_a_tuple   = '0;
      i_a_empty   = 1'b1;
      i_b_tuple   = '0;
      i_b_empty   = 1'b1;
      i_out_ready = 1'b1;
      for (int r = 0; r < NUM_ROWS; r++)
         timeout_limit = timeout_limit + 40 * (rows[r].a_len + rows[r].b_len + 2);
      repeat (16) @(posedge i_clk);
      i_reset <= 1'b0;
      repeat (8) begin   // nothing moves before upstream shows data.
         @(negedge i_clk);
         check_strobe("o_a_read", o_a_read, 1'b0);
         check_strobe("o_b_read", o_b_read, 1'b0);
         check_strobe("o_out_valid", o_out_valid, 1'b0);
      end
      for (int r = 0; r < NUM_ROWS; r++) run_row(r);
      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- tuple_merger.sv
`timescale 1ns/10ps
`default_nettype none

`include "merge_sort_consts.svh"

module tuple_merger (
   input  wire                              i_clk,
   input  wire                              i_reset,
   input  wire merge_sort_pkg::tuple_t      i_a_tuple,
   input  wire                              i_a_empty,
   output logic                             o_a_read,
   input  wire merge_sort_pkg::tuple_t      i_b_tuple,
   input  wire                              i_b_empty,
   output logic                             o_b_read,
   input  wire                              i_out_ready,
   output logic                             o_out_valid,
   output merge_sort_pkg::tuple_t           o_out_tuple
);

   localparam int CNT_W = $clog2(`MS_FIFO_DEPTH + 1);

   merge_sort_pkg::tuple_t      a_head;
   merge_sort_pkg::tuple_t      b_head;
   merge_sort_pkg::tuple_t      merged;
   merge_sort_pkg::merge_cmd_t  cmd;
   logic                        a_empty;
   logic                        a_full;
   logic                        a_deq;
   logic                        b_empty;
   logic                        b_full;
   logic                        b_deq;
   logic                        merged_valid;
   logic                        out_empty;
   logic [CNT_W-1:0]            out_count;

   // the upstream word is valid while its FIFO is non-empty.
   assign o_a_read = ~i_a_empty & ~a_full;
   assign o_b_read = ~i_b_empty & ~b_full;

   assign o_out_valid = i_out_ready & ~out_empty;   // head is popped as it is shown.

   tuple_fifo u_fifo_a (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_data  (i_a_tuple),
      .i_enq   (o_a_read),
      .i_deq   (a_deq),
      .o_data  (a_head),
      .o_empty (a_empty),
      .o_full  (a_full),
      .o_count ()
   );

   tuple_fifo u_fifo_b (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_data  (i_b_tuple),
      .i_enq   (o_b_read),
      .i_deq   (b_deq),
      .o_data  (b_head),
      .o_empty (b_empty),
      .o_full  (b_full),
      .o_count ()
   );

   merge_control u_control (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_a_head    (a_head),
      .i_a_empty   (a_empty),
      .i_b_head    (b_head),
      .i_b_empty   (b_empty),
      .i_out_count (out_count),
      .o_a_deq     (a_deq),
      .o_b_deq     (b_deq),
      .o_cmd       (cmd)
   );

   bitonic_merger u_merger (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_cmd   (cmd),
      .o_valid (merged_valid),
      .o_tuple (merged)
   );

   // control holds off early enough that this FIFO never overflows.
   tuple_fifo u_fifo_out (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_data  (merged),
      .i_enq   (merged_valid),
      .i_deq   (o_out_valid),
      .o_data  (o_out_tuple),
      .o_empty (out_empty),
      .o_full  (),
      .o_count (out_count)
   );

endmodule

`default_nettype wire

//--- bitonic_merger.sv
`timescale 1ns/10ps
`default_nettype none

`include "merge_sort_consts.svh"

module bitonic_merger (
   input  wire                              i_clk,
   input  wire                              i_reset,
   input  wire merge_sort_pkg::merge_cmd_t  i_cmd,
   output logic                             o_valid,
   output merge_sort_pkg::tuple_t           o_tuple
);

   localparam int N = 2 * `MS_KEYS;

   merge_sort_pkg::tuple_t          kept;
   merge_sort_pkg::tuple_t          low;
   merge_sort_pkg::tuple_t          high;
   merge_sort_pkg::key_t [N-1:0]    lvl0;
   merge_sort_pkg::key_t [N-1:0]    lvl1;
   merge_sort_pkg::key_t [N-1:0]    lvl2;
   merge_sort_pkg::key_t [N-1:0]    lvl3;

   // the new tuple rises and the reversed kept tuple falls, so lvl0 is bitonic.
   always_comb begin
      for (int i = 0; i < `MS_KEYS; i++) begin
         lvl0[i]           = i_cmd.data[i];
         lvl0[i+`MS_KEYS]  = kept[`MS_KEYS-1-i];
      end
   end

   // half cleaner across the full eight keys.
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         lvl1[i]   = (lvl0[i] <= lvl0[i+4]) ? lvl0[i] : lvl0[i+4];
         lvl1[i+4] = (lvl0[i] <= lvl0[i+4]) ? lvl0[i+4] : lvl0[i];
      end
   end

   always_comb begin
      for (int h = 0; h < N; h += 4) begin
         for (int i = h; i < h + 2; i++) begin
            lvl2[i]   = (lvl1[i] <= lvl1[i+2]) ? lvl1[i] : lvl1[i+2];
            lvl2[i+2] = (lvl1[i] <= lvl1[i+2]) ? lvl1[i+2] : lvl1[i];
         end
      end
   end

   always_comb begin
      for (int i = 0; i < N; i += 2) begin
         lvl3[i]   = (lvl2[i] <= lvl2[i+1]) ? lvl2[i] : lvl2[i+1];
         lvl3[i+1] = (lvl2[i] <= lvl2[i+1]) ? lvl2[i+1] : lvl2[i];
      end
   end

   always_comb begin
      for (int i = 0; i < `MS_KEYS; i++) begin
         low[i]  = lvl3[i];
         high[i] = lvl3[i+`MS_KEYS];
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         kept    <= '0;
         o_valid <= 1'b0;
      end else begin
         o_valid <= (i_cmd.valid & ~i_cmd.prime) | i_cmd.flush | i_cmd.term;
         if (i_cmd.flush || i_cmd.term) begin
            kept <= '0;   // the next stream starts from an empty kept half.
         end else if (i_cmd.valid && i_cmd.prime) begin
            kept <= i_cmd.data;
         end else if (i_cmd.valid) begin
            kept <= high;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_cmd.flush) begin
         o_tuple <= kept;
      end else if (i_cmd.term) begin
         o_tuple <= '0;
      end else if (i_cmd.valid) begin
         o_tuple <= low;
      end
   end

endmodule

`default_nettype wire

//--- merge_control.sv
`timescale 1ns/10ps
`default_nettype none

`include "merge_sort_consts.svh"

module merge_control (
   input  wire                                    i_clk,
   input  wire                                    i_reset,
   input  wire merge_sort_pkg::tuple_t            i_a_head,
   input  wire                                    i_a_empty,
   input  wire merge_sort_pkg::tuple_t            i_b_head,
   input  wire                                    i_b_empty,
   input  wire [$clog2(`MS_FIFO_DEPTH+1)-1:0]     i_out_count,
   output logic                                   o_a_deq,
   output logic                                   o_b_deq,
   output merge_sort_pkg::merge_cmd_t             o_cmd
);

   localparam int CNT_W = $clog2(`MS_FIFO_DEPTH + 1);

   merge_sort_pkg::ctrl_state_t state;
   merge_sort_pkg::ctrl_state_t state_next;
   logic                        a_term;
   logic                        b_term;
   logic                        a_lte_b;
   logic                        sel_a;
   logic                        heads_ok;
   logic                        out_stall;

   // a zero minimum key marks the terminator tuple.
   assign a_term  = (i_a_head[0] == '0);
   assign b_term  = (i_b_head[0] == '0);
   assign a_lte_b = (i_a_head[0] <= i_b_head[0]);

   // ties go to A. A terminator on one side hands the pick to the other.
   assign sel_a = b_term | (~a_term & a_lte_b);

   assign heads_ok  = ~i_a_empty & ~i_b_empty;
   assign out_stall = (i_out_count >= CNT_W'(`MS_OUT_STALL_LEVEL));

   always_comb begin
      state_next = state;
      o_a_deq    = 1'b0;
      o_b_deq    = 1'b0;
      o_cmd      = '0;
      case (state)
         merge_sort_pkg::ST_PRIME,
         merge_sort_pkg::ST_MERGE: begin
            if (heads_ok && !out_stall) begin
               if (a_term && b_term) begin
                  // nothing is kept after an empty merge, so skip the flush.
                  if (state == merge_sort_pkg::ST_PRIME) begin
                     state_next = merge_sort_pkg::ST_TERM;
                  end else begin
                     state_next = merge_sort_pkg::ST_FLUSH;
                  end
               end else begin
                  o_cmd.valid = 1'b1;
                  o_cmd.prime = (state == merge_sort_pkg::ST_PRIME);
                  o_cmd.data  = sel_a ? i_a_head : i_b_head;
                  o_a_deq     = sel_a;
                  o_b_deq     = ~sel_a;
                  state_next  = merge_sort_pkg::ST_MERGE;
               end
            end
         end
         merge_sort_pkg::ST_FLUSH: begin
            if (!out_stall) begin
               o_cmd.flush = 1'b1;
               state_next  = merge_sort_pkg::ST_TERM;
            end
         end
         merge_sort_pkg::ST_TERM: begin
            if (!out_stall) begin
               o_cmd.term = 1'b1;
               o_a_deq    = 1'b1;   // both heads are terminators here.
               o_b_deq    = 1'b1;
               state_next = merge_sort_pkg::ST_PRIME;
            end
         end
         default: state_next = merge_sort_pkg::ST_PRIME;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         state <= merge_sort_pkg::ST_PRIME;
      end else begin
         state <= state_next;
      end
   end

endmodule

`default_nettype wire

//--- tuple_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "merge_sort_consts.svh"

module tuple_fifo (
   input  wire                                    i_clk,
   input  wire                                    i_reset,
   input  wire merge_sort_pkg::tuple_t            i_data,
   input  wire                                    i_enq,
   input  wire                                    i_deq,
   output merge_sort_pkg::tuple_t                 o_data,
   output logic                                   o_empty,
   output logic                                   o_full,
   output logic [$clog2(`MS_FIFO_DEPTH+1)-1:0]    o_count
);

   localparam int PTR_W = $clog2(`MS_FIFO_DEPTH);
   localparam int CNT_W = $clog2(`MS_FIFO_DEPTH + 1);

   merge_sort_pkg::tuple_t mem [`MS_FIFO_DEPTH];
   logic [PTR_W-1:0]       rd_ptr;
   logic [PTR_W-1:0]       wr_ptr;
   logic [CNT_W-1:0]       count;
   logic                   do_enq;
   logic                   do_deq;

   assign o_empty = (count == '0);
   assign o_full  = (count == CNT_W'(`MS_FIFO_DEPTH));
   assign o_count = count;
   assign o_data  = mem[rd_ptr];   // head is visible without a dequeue.

   assign do_enq = i_enq & ~o_full;   // writes into a full FIFO are dropped.
   assign do_deq = i_deq & ~o_empty;

   always_ff @(posedge i_clk) begin
      if (do_enq) begin
         mem[wr_ptr] <= i_data;
      end
   end

   // the depth is a power of two, so the pointers wrap on their own.
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_enq) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_deq) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_enq, do_deq})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- merge_sort_pkg.sv
`default_nettype none

`include "merge_sort_consts.svh"

package merge_sort_pkg;

   typedef logic [`MS_KEY_W-1:0] key_t;

   // index 0 holds the smallest key.
   typedef key_t [`MS_KEYS-1:0] tuple_t;

   typedef struct packed {
      logic   valid;   // a tuple enters the merger this cycle.
      logic   prime;   // load the kept half only, emit nothing.
      logic   flush;   // emit the kept half.
      logic   term;    // emit the terminator tuple.
      tuple_t data;
   } merge_cmd_t;

   typedef enum logic [1:0] {
      ST_PRIME,
      ST_MERGE,
      ST_FLUSH,
      ST_TERM
   } ctrl_state_t;

endpackage

`default_nettype wire

//--- merge_sort_consts.svh
`ifndef MERGE_SORT_CONSTS_SVH
`define MERGE_SORT_CONSTS_SVH

// width of one unsigned key.
`define MS_KEY_W 32

// keys per tuple, kept in ascending order.
`define MS_KEYS 4

// entries in each tuple FIFO.
`define MS_FIFO_DEPTH 16

// control stops dequeuing when the output FIFO holds this many tuples.
// The three spare entries absorb the tuples still moving through the merger.
`define MS_OUT_STALL_LEVEL 13

`endif
